/* src/sd_pkg.sv */
`default_nettype none

package sd_pkg;

    // one SD block
    localparam int BLOCK_BYTES = 512;

    // first vector block on the card
    localparam logic [31:0] START_BLOCK = 32'h0010_0000;

    // byte position inside a block
    typedef logic [8:0] offset_t;

    // host commands, each strobe held until busy falls
    typedef struct packed {
        logic        host_rst;
        logic        r_block;
        logic        r_byte;
        logic        w_block;
        logic        w_byte;
        logic [31:0] block_addr;
    } sd_cmd_t;

endpackage

`default_nettype wire

/* src/test_pkg.sv */
`default_nettype none

package test_pkg;

    // field sizes in bytes
    localparam int IV_BYTES    = 10;
    localparam int KEY_BYTES   = 10;
    localparam int OUT_BYTES   = 8;
    localparam int TIMER_BYTES = 4;

    // marks a valid vector block
    localparam logic [31:0] SIGNATURE = 32'hAABB_CCDD;

    // block layout, signature occupies bytes 0 to 3
    localparam int ITER_OFFSET  = 4;
    localparam int IV_OFFSET    = 5;
    localparam int KEY_OFFSET   = 15;
    localparam int RECORD_BASE  = 25;
    localparam int RECORD_BYTES = 12;

    // records that fit between RECORD_BASE and the block end
    localparam int MAX_ITER = 40;

    // one result record, out_block goes first on the card
    typedef struct packed {
        logic [OUT_BYTES*8-1:0]   out_block;
        logic [TIMER_BYTES*8-1:0] cycles;
    } result_t;

endpackage

`default_nettype wire

/* src/sector_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module sector_buffer
(
    input  wire                  clk,
    input  wire                  we_i,
    input  wire sd_pkg::offset_t addr_i,
    input  wire [7:0]            data_i,
    output logic [7:0]           data_o
);

    // copy of the block as read from the card
    logic [7:0] mem [sd_pkg::BLOCK_BYTES];

    always_ff @(posedge clk)
    begin
        if (we_i)
            mem[addr_i] <= data_i;
    end

    // one cycle read latency
    always_ff @(posedge clk)
    begin
        data_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

/* src/result_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module result_capture
(
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                running_i,
    input  wire                                capture_i,
    input  wire                                uut_end_i,
    input  wire [test_pkg::OUT_BYTES*8-1:0]    uut_block_i,
    output test_pkg::result_t                  result_o
);

    logic [test_pkg::TIMER_BYTES*8-1:0] timer;

    // zero outside a run, counts cycles until end
    always_ff @(posedge clk)
    begin
        if (rst || !running_i)
            timer <= '0;
        else if (!uut_end_i)
            timer <= timer + 1'b1;
    end

    // block and count taken in the same cycle
    always_ff @(posedge clk)
    begin
        if (capture_i)
        begin
            result_o.out_block <= uut_block_i;
            result_o.cycles    <= timer;
        end
    end

endmodule

`default_nettype wire

/* src/block_fields.sv */
`timescale 1ns/1ps
`default_nettype none

module block_fields
(
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   clear_i,
    input  wire                                   rd_capture_i,
    input  wire                                   wr_load_i,
    input  wire sd_pkg::offset_t                  offset_i,
    input  wire [7:0]                             iter_i,
    input  wire [7:0]                             sd_data_i,
    input  wire [7:0]                             buffer_byte_i,
    input  wire test_pkg::result_t                result_i,
    output logic                                  sig_ok_o,
    output logic [7:0]                            iter_count_o,
    output logic [test_pkg::IV_BYTES*8-1:0]       iv_o,
    output logic [test_pkg::KEY_BYTES*8-1:0]      key_o,
    output logic                                  buf_we_o,
    output logic [7:0]                            sd_data_o
);

    logic [31:0] sig_q;
    logic [7:0]  iter_q;
    logic        in_sig;
    logic        in_iter;
    logic        in_iv;
    logic        in_key;
    logic        in_rec;
    logic        in_out;
    logic [8:0]  iv_idx;
    logic [8:0]  key_idx;
    logic [11:0] rec_base;
    logic [11:0] rec_idx;
    logic [7:0]  wr_byte;

    // layout decode of the current offset
    assign in_sig  = offset_i < 9'(test_pkg::ITER_OFFSET);
    assign in_iter = offset_i == 9'(test_pkg::ITER_OFFSET);
    assign in_iv   = offset_i >= 9'(test_pkg::IV_OFFSET)
                  && offset_i < 9'(test_pkg::IV_OFFSET + test_pkg::IV_BYTES);
    assign in_key  = offset_i >= 9'(test_pkg::KEY_OFFSET)
                  && offset_i < 9'(test_pkg::KEY_OFFSET + test_pkg::KEY_BYTES);
    assign iv_idx  = offset_i - 9'(test_pkg::IV_OFFSET);
    assign key_idx = offset_i - 9'(test_pkg::KEY_OFFSET);

    // record window of this iteration
    assign rec_base = 12'(test_pkg::RECORD_BASE) + 12'(iter_i) * 12'(test_pkg::RECORD_BYTES);
    assign rec_idx  = 12'(offset_i) - rec_base;
    assign in_rec   = 12'(offset_i) >= rec_base && rec_idx < 12'(test_pkg::RECORD_BYTES);
    assign in_out   = rec_idx < 12'(test_pkg::OUT_BYTES);

    // header and key material live in registers, not in the buffer
    assign buf_we_o = rd_capture_i && !(in_sig || in_iter || in_iv || in_key);

    assign sig_ok_o = sig_q == test_pkg::SIGNATURE;

    always_comb
    begin
        if (iter_q == 8'd0)
            iter_count_o = 8'd1;
        else if (iter_q > 8'(test_pkg::MAX_ITER))
            iter_count_o = 8'(test_pkg::MAX_ITER);
        else
            iter_count_o = iter_q;
    end

    always_ff @(posedge clk)
    begin
        if (rst || clear_i)
        begin
            sig_q  <= '0;
            iter_q <= '0;
        end
        else if (rd_capture_i)
        begin
            // signature arrives MSB first
            if (in_sig)
                sig_q[{2'd3 - offset_i[1:0], 3'b000} +: 8] <= sd_data_i;
            if (in_iter)
                iter_q <= sd_data_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (clear_i)
        begin
            iv_o  <= '0;
            key_o <= '0;
        end
        else if (rd_capture_i)
        begin
            if (in_iv)
                iv_o[{iv_idx[3:0], 3'b000} +: 8] <= sd_data_i;
            if (in_key)
                key_o[{key_idx[3:0], 3'b000} +: 8] <= sd_data_i;
        end
    end

    always_comb
    begin
        if (in_sig)
            wr_byte = 8'(sig_q >> {2'd3 - offset_i[1:0], 3'b000});
        else if (in_iter)
            wr_byte = iter_q;
        else if (in_iv)
            wr_byte = 8'(iv_o >> {iv_idx[3:0], 3'b000});
        else if (in_key)
            wr_byte = 8'(key_o >> {key_idx[3:0], 3'b000});
        else if (in_rec && in_out)
            wr_byte = 8'(result_i.out_block >> {rec_idx[2:0], 3'b000});
        else if (in_rec)
            wr_byte = 8'(result_i.cycles >> {rec_idx[1:0], 3'b000});
        else
            wr_byte = buffer_byte_i;
    end

    // held for the whole w_byte handshake
    always_ff @(posedge clk)
    begin
        if (wr_load_i)
            sd_data_o <= wr_byte;
    end

    a_capture_range: assert property (@(posedge clk) disable iff (rst)
        rd_capture_i |-> (32'(offset_i) < sd_pkg::BLOCK_BYTES) && !wr_load_i);

endmodule

`default_nettype wire

/* src/autotest_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module autotest_fsm
(
    input  wire             clk,
    input  wire             rst,
    input  wire             sd_busy_i,
    input  wire             sig_ok_i,
    input  wire [7:0]       iter_count_i,
    input  wire             uut_end_i,
    output sd_pkg::sd_cmd_t sd_cmd_o,
    output logic            uut_rst_o,
    output logic            clear_o,
    output logic            rd_capture_o,
    output logic            wr_load_o,
    output logic            running_o,
    output logic            capture_o,
    output sd_pkg::offset_t offset_o,
    output logic [7:0]      iter_o
);

    typedef enum logic [4:0] {
        INIT,
        HOST_RST,
        HOST_WAIT,
        RD_BLOCK,
        RD_BLOCK_WAIT,
        RD_BYTE,
        RD_BYTE_WAIT,
        RD_CAPTURE,
        CHECK,
        RUN,
        CAPTURE,
        WR_BLOCK,
        WR_BLOCK_WAIT,
        WR_FETCH,
        WR_LOAD,
        WR_BYTE,
        WR_BYTE_WAIT,
        NEXT,
        HALT
    } state_t;

    state_t      state;
    state_t      state_next;
    logic [31:0] block_addr;
    logic        step_offset;
    logic        step_iter;
    logic        last_byte;
    logic        last_iter;

    assign last_byte = offset_o == sd_pkg::offset_t'(sd_pkg::BLOCK_BYTES - 1);
    assign last_iter = (9'(iter_o) + 9'd1) >= 9'(iter_count_i);

    always_comb
    begin
        state_next          = state;
        sd_cmd_o            = '0;
        sd_cmd_o.block_addr = block_addr;
        uut_rst_o           = 1'b1;
        clear_o             = 1'b0;
        rd_capture_o        = 1'b0;
        wr_load_o           = 1'b0;
        running_o           = 1'b0;
        capture_o           = 1'b0;
        step_offset         = 1'b0;
        step_iter           = 1'b0;

        case (state)
            INIT:
                state_next = HOST_RST;
            HOST_RST:
            begin
                sd_cmd_o.host_rst = 1'b1;
                if (sd_busy_i)
                    state_next = HOST_WAIT;
            end
            HOST_WAIT:
            begin
                sd_cmd_o.host_rst = 1'b1;
                if (!sd_busy_i)
                    state_next = RD_BLOCK;
            end
            // fields are reloaded on every pass
            RD_BLOCK:
            begin
                sd_cmd_o.r_block = 1'b1;
                clear_o          = 1'b1;
                if (sd_busy_i)
                    state_next = RD_BLOCK_WAIT;
            end
            RD_BLOCK_WAIT:
            begin
                sd_cmd_o.r_block = 1'b1;
                if (!sd_busy_i)
                    state_next = RD_BYTE;
            end
            RD_BYTE:
            begin
                sd_cmd_o.r_block = 1'b1;
                sd_cmd_o.r_byte  = 1'b1;
                if (sd_busy_i)
                    state_next = RD_BYTE_WAIT;
            end
            RD_BYTE_WAIT:
            begin
                sd_cmd_o.r_block = 1'b1;
                sd_cmd_o.r_byte  = 1'b1;
                if (!sd_busy_i)
                    state_next = RD_CAPTURE;
            end
            // sd_data_i is valid here, offset wraps to 0 after 511
            RD_CAPTURE:
            begin
                sd_cmd_o.r_block = 1'b1;
                rd_capture_o     = 1'b1;
                step_offset      = 1'b1;
                state_next       = last_byte ? CHECK : RD_BYTE;
            end
            CHECK:
                state_next = sig_ok_i ? RUN : HALT;
            RUN:
            begin
                uut_rst_o = 1'b0;
                running_o = 1'b1;
                if (uut_end_i)
                    state_next = CAPTURE;
            end
            CAPTURE:
            begin
                capture_o  = 1'b1;
                state_next = WR_BLOCK;
            end
            WR_BLOCK:
            begin
                sd_cmd_o.w_block = 1'b1;
                if (sd_busy_i)
                    state_next = WR_BLOCK_WAIT;
            end
            WR_BLOCK_WAIT:
            begin
                sd_cmd_o.w_block = 1'b1;
                if (!sd_busy_i)
                    state_next = WR_FETCH;
            end
            // one cycle for the buffer read
            WR_FETCH:
            begin
                sd_cmd_o.w_block = 1'b1;
                state_next       = WR_LOAD;
            end
            WR_LOAD:
            begin
                sd_cmd_o.w_block = 1'b1;
                wr_load_o        = 1'b1;
                state_next       = WR_BYTE;
            end
            WR_BYTE:
            begin
                sd_cmd_o.w_block = 1'b1;
                sd_cmd_o.w_byte  = 1'b1;
                if (sd_busy_i)
                    state_next = WR_BYTE_WAIT;
            end
            WR_BYTE_WAIT:
            begin
                sd_cmd_o.w_block = 1'b1;
                sd_cmd_o.w_byte  = 1'b1;
                if (!sd_busy_i)
                begin
                    step_offset = 1'b1;
                    state_next  = last_byte ? NEXT : WR_FETCH;
                end
            end
            NEXT:
            begin
                step_iter  = 1'b1;
                state_next = RD_BLOCK;
            end
            // bad signature, stay here until reset
            HALT:
                state_next = HALT;
            default:
                state_next = INIT;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= INIT;
            offset_o   <= '0;
            iter_o     <= '0;
            block_addr <= sd_pkg::START_BLOCK;
        end
        else
        begin
            state <= state_next;
            if (step_offset)
                offset_o <= offset_o + 9'd1;
            if (step_iter)
            begin
                if (last_iter)
                begin
                    iter_o     <= '0;
                    block_addr <= block_addr + 32'd1;
                end
                else
                    iter_o <= iter_o + 8'd1;
            end
        end
    end

    a_block_excl: assert property (@(posedge clk) disable iff (rst)
        !(sd_cmd_o.r_block && sd_cmd_o.w_block));

    a_rd_byte_nested: assert property (@(posedge clk) disable iff (rst)
        sd_cmd_o.r_byte |-> sd_cmd_o.r_block);

    a_wr_byte_nested: assert property (@(posedge clk) disable iff (rst)
        sd_cmd_o.w_byte |-> sd_cmd_o.w_block);

endmodule

`default_nettype wire

/* src/autotest_top.sv */
`timescale 1ns/1ps
`default_nettype none

module autotest_top
(
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    sd_busy_i,
    input  wire [7:0]                              sd_data_i,
    output sd_pkg::sd_cmd_t                        sd_cmd_o,
    output logic [7:0]                             sd_data_o,
    input  wire [test_pkg::OUT_BYTES*8-1:0]        uut_block_i,
    input  wire                                    uut_end_i,
    output logic                                   uut_rst_o,
    output logic [test_pkg::IV_BYTES*8-1:0]        uut_iv_o,
    output logic [test_pkg::KEY_BYTES*8-1:0]       uut_key_o
);

    logic              clear;
    logic              rd_capture;
    logic              wr_load;
    logic              running;
    logic              capture;
    sd_pkg::offset_t   offset;
    logic [7:0]        iter;
    logic              sig_ok;
    logic [7:0]        iter_count;
    logic              buf_we;
    logic [7:0]        buf_byte;
    test_pkg::result_t result;

    autotest_fsm u_fsm (
        .clk          (clk),
        .rst          (rst),
        .sd_busy_i    (sd_busy_i),
        .sig_ok_i     (sig_ok),
        .iter_count_i (iter_count),
        .uut_end_i    (uut_end_i),
        .sd_cmd_o     (sd_cmd_o),
        .uut_rst_o    (uut_rst_o),
        .clear_o      (clear),
        .rd_capture_o (rd_capture),
        .wr_load_o    (wr_load),
        .running_o    (running),
        .capture_o    (capture),
        .offset_o     (offset),
        .iter_o       (iter)
    );

    block_fields u_fields (
        .clk           (clk),
        .rst           (rst),
        .clear_i       (clear),
        .rd_capture_i  (rd_capture),
        .wr_load_i     (wr_load),
        .offset_i      (offset),
        .iter_i        (iter),
        .sd_data_i     (sd_data_i),
        .buffer_byte_i (buf_byte),
        .result_i      (result),
        .sig_ok_o      (sig_ok),
        .iter_count_o  (iter_count),
        .iv_o          (uut_iv_o),
        .key_o         (uut_key_o),
        .buf_we_o      (buf_we),
        .sd_data_o     (sd_data_o)
    );

    sector_buffer u_buffer (
        .clk    (clk),
        .we_i   (buf_we),
        .addr_i (offset),
        .data_i (sd_data_i),
        .data_o (buf_byte)
    );

    result_capture u_result (
        .clk         (clk),
        .rst         (rst),
        .running_i   (running),
        .capture_i   (capture),
        .uut_end_i   (uut_end_i),
        .uut_block_i (uut_block_i),
        .result_o    (result)
    );

endmodule

`default_nettype wire

/* bench/sd_card_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_card_model
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire sd_pkg::sd_cmd_t cmd_i,
    input  wire [7:0]            data_i,
    output logic                 busy_o,
    output logic [7:0]           data_o,
    output int                   reads_o,
    output int                   writes_o,
    output int                   errors_o
);

    localparam int BLOCKS = 4;
    localparam int BLK    = sd_pkg::BLOCK_BYTES;

    // block k of the card holds address START_BLOCK + k
    logic [7:0]      mem [BLOCKS*BLK];
    integer          seed = 32'h9993f0ad;
    sd_pkg::sd_cmd_t now_cmd;
    sd_pkg::sd_cmd_t prev_cmd;
    int              base;
    int              rd_ptr;
    int              wr_ptr;

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // read data changes together with the falling busy
    task automatic handshake(input bit read_byte);
        repeat (rand_range(1, 3)) @(posedge clk);
        #1;
        busy_o = 1'b1;
        repeat (rand_range(1, 4)) @(posedge clk);
        #1;
        if (read_byte)
        begin
            data_o = mem[base + rd_ptr];
            rd_ptr++;
        end
        busy_o = 1'b0;
    endtask

    task automatic open_block(input logic [31:0] addr);
        if (addr < sd_pkg::START_BLOCK || addr >= sd_pkg::START_BLOCK + BLOCKS)
        begin
            $display("SD card model: block address %h is not on the card", addr);
            errors_o++;
            base = 0;
        end
        else
            base = int'(addr - sd_pkg::START_BLOCK) * BLK;
    endtask

    initial
    begin
        busy_o   = 1'b0;
        data_o   = 8'h00;
        reads_o  = 0;
        writes_o = 0;
        errors_o = 0;
        prev_cmd = '0;
        for (int i = 0; i < BLOCKS * BLK; i++)
            mem[i] = 8'($random(seed));
        for (int b = 0; b < 3; b++)
        begin
            for (int i = 0; i < 4; i++)
                mem[b*BLK + i] = 8'(test_pkg::SIGNATURE >> (8 * (3 - i)));
        end
        mem[test_pkg::ITER_OFFSET]       = 8'd3;
        mem[BLK + test_pkg::ITER_OFFSET] = 8'd0;
        // third block carries a broken signature
        mem[2*BLK + 3] = mem[2*BLK + 3] ^ 8'h01;

        forever
        begin
            @(posedge clk);
            #1;
            now_cmd = cmd_i;
            if (rst)
                now_cmd = '0;
            else if (now_cmd.host_rst && !prev_cmd.host_rst)
                handshake(1'b0);
            else if (now_cmd.r_block && !prev_cmd.r_block)
            begin
                open_block(now_cmd.block_addr);
                rd_ptr = 0;
                handshake(1'b0);
            end
            else if (now_cmd.r_byte && !prev_cmd.r_byte)
            begin
                handshake(1'b1);
                if (rd_ptr == BLK)
                    reads_o++;
            end
            else if (now_cmd.w_block && !prev_cmd.w_block)
            begin
                open_block(now_cmd.block_addr);
                wr_ptr = 0;
                handshake(1'b0);
            end
            else if (now_cmd.w_byte && !prev_cmd.w_byte)
            begin
                mem[base + wr_ptr] = data_i;
                wr_ptr++;
                handshake(1'b0);
                if (wr_ptr == BLK)
                    writes_o++;
            end
            prev_cmd = now_cmd;
        end
    end

endmodule

`default_nettype wire

/* bench/tb_autotest.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_autotest;

    localparam int WAIT_CYCLES = 20000;
    localparam int HALT_CYCLES = 3000;
    localparam int END_CYCLES  = 10;
    localparam int BLK         = sd_pkg::BLOCK_BYTES;

    logic            clk;
    logic            rst;
    logic            sd_busy;
    logic [7:0]      sd_rdata;
    sd_pkg::sd_cmd_t sd_cmd;
    logic [7:0]      sd_wdata;
    logic [63:0]     uut_block;
    logic            uut_end;
    logic            uut_rst;
    logic [79:0]     uut_iv;
    logic [79:0]     uut_key;
    int              card_reads;
    int              card_writes;
    int              card_errors;
    integer          seed = 32'h9993f0ad;
    int              errors;
    int              tests;
    int              low_cycles;
    int              run_mark;
    // expected card contents of the first three blocks
    logic [7:0]      image [3*BLK];

    autotest_top uut (
        .clk         (clk),
        .rst         (rst),
        .sd_busy_i   (sd_busy),
        .sd_data_i   (sd_rdata),
        .sd_cmd_o    (sd_cmd),
        .sd_data_o   (sd_wdata),
        .uut_block_i (uut_block),
        .uut_end_i   (uut_end),
        .uut_rst_o   (uut_rst),
        .uut_iv_o    (uut_iv),
        .uut_key_o   (uut_key)
    );

    sd_card_model card (
        .clk      (clk),
        .rst      (rst),
        .cmd_i    (sd_cmd),
        .data_i   (sd_wdata),
        .busy_o   (sd_busy),
        .data_o   (sd_rdata),
        .reads_o  (card_reads),
        .writes_o (card_writes),
        .errors_o (card_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    // stand-in for the cipher output
    function automatic logic [63:0] cipher_stub(input logic [79:0] iv, input logic [79:0] key);
        return iv[63:0] ^ key[79:16] ^ {iv[79:64], key[15:0], 32'h5a5a_c3c3};
    endfunction

    function automatic logic [79:0] image_field(input int base, input int offset);
        logic [79:0] value;
        for (int i = 0; i < 10; i++)
            value[8*i +: 8] = image[base + offset + i];
        return value;
    endfunction

    function automatic int first_difference(input int base);
        for (int i = 0; i < BLK; i++)
        begin
            if (card.mem[base + i] !== image[base + i])
                return i;
        end
        return 0;
    endfunction

    function automatic logic [4:0] strobes();
        return {sd_cmd.host_rst, sd_cmd.r_block, sd_cmd.r_byte, sd_cmd.w_block, sd_cmd.w_byte};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [79:0] expected,
                               input logic [79:0] actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before)
            $display("test %s passed", name);
        else
            $display("test %s failed", name);
    endtask

    task automatic end_run();
        errors += card_errors;
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    endtask

    task automatic timeout_fail(input string what, input int limit);
        $display("Timeout: no %s within %0d cycles", what, limit);
        errors++;
        end_run();
    endtask

    task automatic wait_read_start(input logic [31:0] addr, input string name);
        int n;
        n = 0;
        while (sd_cmd.r_block !== 1'b1)
        begin
            next_cycle();
            n++;
            if (n > WAIT_CYCLES)
                timeout_fail("block read", WAIT_CYCLES);
        end
        check_value(name, addr, sd_cmd.block_addr);
    endtask

    task automatic wait_run_start();
        int n;
        n = 0;
        while (uut_rst !== 1'b0)
        begin
            next_cycle();
            n++;
            if (n > WAIT_CYCLES)
                timeout_fail("UUT run", WAIT_CYCLES);
        end
    endtask

    task automatic wait_card(input bit writes, input int target, input string what);
        int n;
        n = 0;
        while ((writes ? card_writes : card_reads) < target)
        begin
            next_cycle();
            n++;
            if (n > WAIT_CYCLES)
                timeout_fail(what, WAIT_CYCLES);
        end
    endtask

    // rising edges the DUT timer should count
    always @(negedge clk)
    begin
        if (uut_rst === 1'b0 && uut_end === 1'b0)
            low_cycles++;
    end

    initial
    begin : uut_stand_in
        int delay;
        int n;
        uut_end   = 1'b0;
        uut_block = '0;
        run_mark  = 0;
        forever
        begin
            next_cycle();
            if (!rst && uut_rst === 1'b0 && !uut_end)
            begin
                run_mark  = low_cycles;
                delay     = 5 + int'($unsigned($random(seed)) % 36);
                uut_block = cipher_stub(uut_iv, uut_key);
                repeat (delay) next_cycle();
                uut_end = 1'b1;
                n = 0;
                while (uut_rst !== 1'b1)
                begin
                    next_cycle();
                    n++;
                    if (n > END_CYCLES)
                        timeout_fail("UUT reset after end", END_CYCLES);
                end
                uut_end = 1'b0;
            end
        end
    end

    initial
    begin : main_flow
        int          errs;
        int          runs;
        int          rec;
        int          bad;
        int          active;
        logic [79:0] exp_iv;
        logic [79:0] exp_key;
        logic [63:0] exp_block;
        logic [31:0] cycles;
        logic [31:0] next_addr;
        string       name;

        errors = 0;
        tests  = 0;
        rst    = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        errs = errors;
        check_value("reset strobes", 0, strobes());
        check_value("reset uut_rst", 1, uut_rst);
        for (int i = 0; i < 3 * BLK; i++)
            image[i] = card.mem[i];
        rst = 1'b0;
        report_test("reset_state", errs);

        errs = errors;
        wait_read_start(sd_pkg::START_BLOCK, "first read address");
        report_test("first_read", errs);

        for (int b = 0; b < 2; b++)
        begin
            // stored count, at least 1, at most MAX_ITER
            runs = int'(image[b*BLK + test_pkg::ITER_OFFSET]);
            if (runs == 0)
                runs = 1;
            if (runs > test_pkg::MAX_ITER)
                runs = test_pkg::MAX_ITER;
            for (int n = 0; n < runs; n++)
            begin
                errs = errors;
                name = $sformatf("block%0d_run%0d", b, n);
                wait_run_start();
                exp_iv  = image_field(b*BLK, test_pkg::IV_OFFSET);
                exp_key = image_field(b*BLK, test_pkg::KEY_OFFSET);
                check_value({name, " iv"}, exp_iv, uut_iv);
                check_value({name, " key"}, exp_key, uut_key);
                wait_card(1'b1, card_writes + 1, "block write");

                exp_block = cipher_stub(exp_iv, exp_key);
                cycles    = 32'(low_cycles - run_mark);
                rec       = b*BLK + test_pkg::RECORD_BASE + n*test_pkg::RECORD_BYTES;
                for (int i = 0; i < 8; i++)
                    image[rec + i] = exp_block[8*i +: 8];
                for (int i = 0; i < 4; i++)
                    image[rec + 8 + i] = cycles[8*i +: 8];
                bad = first_difference(b*BLK);
                check_value($sformatf("%s written byte %0d", name, bad),
                            image[b*BLK + bad], card.mem[b*BLK + bad]);

                next_addr = sd_pkg::START_BLOCK + b + ((n == runs - 1) ? 1 : 0);
                wait_read_start(next_addr, {name, " next read address"});
                report_test(name, errs);
            end
        end

        errs = errors;
        wait_card(1'b0, card_reads + 1, "read of the bad signature block");
        repeat (3) next_cycle();
        active = 0;
        bad    = card_writes;
        for (int i = 0; i < HALT_CYCLES; i++)
        begin
            next_cycle();
            if (uut_rst !== 1'b1 || strobes() !== 5'b0)
                active++;
        end
        check_value("cycles active after bad signature", 0, active);
        check_value("writes after bad signature", bad, card_writes);
        report_test("halt_bad_signature", errs);

        end_run();
    end

endmodule

`default_nettype wire

/* tb.f */
src/sd_pkg.sv
src/test_pkg.sv
src/sector_buffer.sv
src/result_capture.sv
src/block_fields.sv
src/autotest_fsm.sv
src/autotest_top.sv
bench/sd_card_model.sv
bench/tb_autotest.sv

/* Bender.yml */
package:
  name: autotest

sources:
  - src/sd_pkg.sv
  - src/test_pkg.sv
  - src/sector_buffer.sv
  - src/result_capture.sv
  - src/block_fields.sv
  - src/autotest_fsm.sv
  - src/autotest_top.sv
  - target: test
    files:
      - bench/sd_card_model.sv
      - bench/tb_autotest.sv
